// ==== source/spi_pwm_pkg.sv ====
package spi_pwm_pkg;

	// Register file geometry
	localparam int ADDR_W = 3;
	localparam int DATA_W = 8;
	localparam int NUM_CH = 4;
	localparam int CH_W   = $clog2(NUM_CH);

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;

	// Register map
	localparam addr_t REG_DUTY0   = 3'd0;	// Duty of channel n at REG_DUTY0 + n
	localparam addr_t REG_ENABLE  = 3'd4;
	localparam addr_t REG_PRESC   = 3'd5;
	localparam addr_t REG_SCRATCH = 3'd6;
	localparam addr_t REG_ID      = 3'd7;

	localparam data_t ID_VALUE = 8'hA5;

	// SPI framing
	localparam int SYNC_STAGES  = 2;
	localparam int CMD_READ_BIT = 7;	// Set in the command byte for a read
	localparam int FRAME_BITS   = 2 * DATA_W;	// Command byte plus one data byte
	localparam int CNT_W        = $clog2(FRAME_BITS + 1);

endpackage

// ==== source/reg_bus_if.sv ====
`timescale 1ns/1ps

interface reg_bus_if;
	import spi_pwm_pkg::*;

	addr_t addr;
	data_t wdata;
	logic  wr_en;	// One-cycle write strobe
	data_t rdata;	// Combinational from addr

	modport target (
		output addr,
		output wdata,
		output wr_en,
		input  rdata
	);

	modport bank (
		input  addr,
		input  wdata,
		input  wr_en,
		output rdata
	);

endinterface

// ==== source/spi_target.sv ====
`timescale 1ns/1ps

module spi_target (
	input  logic clk,
	input  logic cs,
	input  logic spi_sclk,
	input  logic spi_mosi,
	input  logic spi_ss,	// Active low select
	output logic spi_miso,
	reg_bus_if.target bus
);
	import spi_pwm_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_COMMAND,
		ST_WRITE,
		ST_READ
	} state_t;

	logic [SYNC_STAGES-1:0] sclk_sync;
	logic [SYNC_STAGES-1:0] mosi_sync;
	logic [SYNC_STAGES-1:0] ss_sync;
	logic sclk_s;
	logic mosi_s;
	logic ss_s;
	logic sclk_q;
	logic sclk_rise;
	logic sclk_fall;

	state_t state;
	logic [CNT_W-1:0] bit_cnt;
	logic wr_en_q;
	logic miso_q;
	data_t shift_reg;
	data_t shift_next;
	data_t tx_reg;
	addr_t addr_q;

	logic cmd_done;
	logic data_done;
	logic read_load;
	logic read_shift;

	// Pin synchronizers plus the SCLK edge flop
	always_ff @(posedge clk, posedge cs) begin
		if (cs) begin
			sclk_sync <= '0;
			mosi_sync <= '0;
			ss_sync   <= '1;	// Deselected out of reset
			sclk_q    <= 1'b0;
		end else begin
			sclk_sync <= {sclk_sync[SYNC_STAGES-2:0], spi_sclk};
			mosi_sync <= {mosi_sync[SYNC_STAGES-2:0], spi_mosi};
			ss_sync   <= {ss_sync[SYNC_STAGES-2:0], spi_ss};
			sclk_q    <= sclk_s;
		end
	end

	assign sclk_s = sclk_sync[SYNC_STAGES-1];
	assign mosi_s = mosi_sync[SYNC_STAGES-1];
	assign ss_s   = ss_sync[SYNC_STAGES-1];

	assign sclk_rise = sclk_s & ~sclk_q;
	assign sclk_fall = ~sclk_s & sclk_q;

	// MOSI is sampled on falling SCLK (CPOL 0, CPHA 1)
	assign shift_next = {shift_reg[DATA_W-2:0], mosi_s};

	assign cmd_done   = sclk_fall && (state == ST_COMMAND) &&
		(bit_cnt == CNT_W'(DATA_W - 1));
	assign data_done  = sclk_fall && (state == ST_WRITE) &&
		(bit_cnt == CNT_W'(FRAME_BITS - 1));

	// First rising edge after the command loads the read byte
	assign read_load  = sclk_rise && (state == ST_READ) && (bit_cnt == CNT_W'(DATA_W));
	assign read_shift = sclk_rise && (state == ST_READ) && (bit_cnt != CNT_W'(DATA_W));

	// Frame control is cleared while the synchronized select is high
	always_ff @(posedge clk, posedge cs, posedge ss_s) begin
		if (cs || ss_s) begin
			state   <= ST_IDLE;
			bit_cnt <= '0;
			wr_en_q <= 1'b0;
			miso_q  <= 1'b0;
		end else begin
			wr_en_q <= 1'b0;

			// Saturate so extra clocks cannot start a second frame
			if (sclk_fall && bit_cnt != CNT_W'(FRAME_BITS))
				bit_cnt <= bit_cnt + 1'b1;

			case (state)
				ST_IDLE: begin
					state <= ST_COMMAND;
				end
				ST_COMMAND: begin
					if (cmd_done)
						state <= shift_next[CMD_READ_BIT] ? ST_READ : ST_WRITE;
				end
				ST_WRITE: begin
					if (data_done)
						wr_en_q <= 1'b1;	// Last data bit just arrived
				end
				ST_READ: begin
					if (read_load)
						miso_q <= bus.rdata[DATA_W-1];
					else if (read_shift)
						miso_q <= tx_reg[DATA_W-2];
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Payload registers
	always_ff @(posedge clk) begin
		if (sclk_fall)
			shift_reg <= shift_next;
		if (cmd_done)
			addr_q <= shift_next[ADDR_W-1:0];
		if (read_load)
			tx_reg <= bus.rdata;
		else if (read_shift)
			tx_reg <= {tx_reg[DATA_W-2:0], 1'b0};
	end

	assign bus.addr  = addr_q;
	assign bus.wdata = shift_reg;	// Holds the full data byte while wr_en is high
	assign bus.wr_en = wr_en_q;

	assign spi_miso = miso_q;

endmodule

// ==== source/pwm_reg_bank.sv ====
`timescale 1ns/1ps

module pwm_reg_bank (
	input  logic clk,
	input  logic cs,
	reg_bus_if.bank bus,
	output spi_pwm_pkg::data_t duty [spi_pwm_pkg::NUM_CH],
	output logic [spi_pwm_pkg::NUM_CH-1:0] enable,
	output logic tick
);
	import spi_pwm_pkg::*;

	data_t duty_reg [NUM_CH];
	data_t enable_reg;
	data_t presc_reg;
	data_t scratch_reg;
	data_t presc_cnt;

	logic addr_is_duty;
	logic [CH_W-1:0] duty_sel;

	assign addr_is_duty = (bus.addr >= REG_DUTY0) &&
		(bus.addr < addr_t'(REG_DUTY0 + NUM_CH));
	assign duty_sel = CH_W'(bus.addr - REG_DUTY0);

	always_ff @(posedge clk, posedge cs) begin
		if (cs) begin
			for (int i = 0; i < NUM_CH; i++)
				duty_reg[i] <= '0;
			enable_reg  <= '0;
			presc_reg   <= '0;
			scratch_reg <= '0;
		end else if (bus.wr_en) begin
			if (addr_is_duty) begin
				duty_reg[duty_sel] <= bus.wdata;
			end else begin
				case (bus.addr)
					REG_ENABLE:  enable_reg  <= bus.wdata;
					REG_PRESC:   presc_reg   <= bus.wdata;
					REG_SCRATCH: scratch_reg <= bus.wdata;
					default: ;	// REG_ID is read-only
				endcase
			end
		end
	end

	// Read mux
	always_comb begin
		bus.rdata = '0;
		if (addr_is_duty) begin
			bus.rdata = duty_reg[duty_sel];
		end else begin
			case (bus.addr)
				REG_ENABLE:  bus.rdata = enable_reg;
				REG_PRESC:   bus.rdata = presc_reg;
				REG_SCRATCH: bus.rdata = scratch_reg;
				REG_ID:      bus.rdata = ID_VALUE;
				default:     bus.rdata = '0;
			endcase
		end
	end

	// Prescaler gives one tick every presc_reg + 1 cycles
	// A lowered divide value ends the current count at once
	assign tick = (presc_cnt >= presc_reg);

	always_ff @(posedge clk, posedge cs) begin
		if (cs)
			presc_cnt <= '0;
		else if (tick)
			presc_cnt <= '0;
		else
			presc_cnt <= presc_cnt + 1'b1;
	end

	assign duty   = duty_reg;
	assign enable = enable_reg[NUM_CH-1:0];	// Upper bits only read back

endmodule

// ==== source/pwm_channel.sv ====
`timescale 1ns/1ps

module pwm_channel (
	input  logic clk,
	input  logic cs,
	input  logic tick,
	input  logic enable,
	input  spi_pwm_pkg::data_t duty,
	output logic pwm_out
);
	import spi_pwm_pkg::*;

	data_t period_cnt;
	data_t duty_shadow;	// Duty in use for the current period
	logic  wrap;

	assign wrap = tick && (period_cnt == '1);

	always_ff @(posedge clk, posedge cs) begin
		if (cs) begin
			period_cnt  <= '0;
			duty_shadow <= '0;
		end else if (!enable) begin
			period_cnt <= '0;	// Restart the period when enabled again
		end else if (tick) begin
			period_cnt <= period_cnt + 1'b1;	// Wraps 255 -> 0
			if (wrap)
				duty_shadow <= duty;
		end
	end

	// Disable acts on the output without waiting for the counter
	assign pwm_out = enable && (period_cnt < duty_shadow);

endmodule

// ==== source/spi_pwm_top.sv ====
`timescale 1ns/1ps

module spi_pwm_top (
	input  logic clk,
	input  logic cs,
	input  logic spi_sclk,
	input  logic spi_mosi,
	input  logic spi_ss,
	output logic spi_miso,
	output logic [spi_pwm_pkg::NUM_CH-1:0] pwm_out
);
	import spi_pwm_pkg::*;

	data_t duty [NUM_CH];
	logic [NUM_CH-1:0] enable;
	logic tick;	// Shared prescaler tick

	reg_bus_if bus ();

	spi_target spi_target_inst (
		.clk      (clk),
		.cs       (cs),
		.spi_sclk (spi_sclk),
		.spi_mosi (spi_mosi),
		.spi_ss   (spi_ss),
		.spi_miso (spi_miso),
		.bus      (bus.target)
	);

	pwm_reg_bank pwm_reg_bank_inst (
		.clk    (clk),
		.cs     (cs),
		.bus    (bus.bank),
		.duty   (duty),
		.enable (enable),
		.tick   (tick)
	);

	for (genvar n = 0; n < NUM_CH; n++) begin : g_ch
		pwm_channel pwm_channel_inst (
			.clk     (clk),
			.cs      (cs),
			.tick    (tick),
			.enable  (enable[n]),
			.duty    (duty[n]),
			.pwm_out (pwm_out[n])
		);
	end

endmodule

// ==== verif/spi_pwm_properties.sv ====
`timescale 1ns/1ps

module spi_pwm_properties (
	input logic clk,
	input logic cs,
	input logic ss_s,	// Synchronized select, high when deselected
	input logic wr_en,
	input logic miso,
	input logic idle
);

	// Write strobe is a single-cycle pulse
	a_wr_en_single: assert property (@(posedge clk) disable iff (cs)
		wr_en |=> !wr_en)
		else $error("wr_en stayed high for two cycles in a row");

	a_wr_en_selected: assert property (@(posedge clk) disable iff (cs)
		$rose(wr_en) |-> !ss_s)
		else $error("wr_en rose while the SPI select was high");

	// No data is shifted out between frames
	a_miso_idle: assert property (@(posedge clk) disable iff (cs)
		idle |-> !miso)
		else $error("spi_miso was high while the SPI target was idle");

endmodule

bind spi_target spi_pwm_properties spi_pwm_properties_inst (
	.clk   (clk),
	.cs    (cs),
	.ss_s  (ss_s),
	.wr_en (wr_en_q),
	.miso  (miso_q),
	.idle  (state == ST_IDLE)
);

// ==== verif/spi_pwm_tb.sv ====
`timescale 1ns/1ps

module spi_pwm_tb;
	import spi_pwm_pkg::*;

	localparam int CLK_PERIOD    = 4;
	localparam int RESET_CYCLES  = 16;
	localparam int HALF_SCLK     = 8;	// clk cycles per SCLK half period
	localparam int NUM_TRANSFERS = 32;	// SPI frames over all five tests
	localparam int PWM_WINDOWS   = 3;
	localparam int MAX_PERIOD    = 256 * 4;	// Prescaler of 3 at most
	localparam int WATCHDOG_NS   =
		2 * (NUM_TRANSFERS * 16 * 16 + PWM_WINDOWS * MAX_PERIOD) * CLK_PERIOD;

	logic clk;
	logic cs;
	logic spi_sclk;
	logic spi_mosi;
	logic spi_ss;
	logic spi_miso;
	logic [NUM_CH-1:0] pwm_out;

	data_t  model_regs [8];	// Shadow copy of the register map
	int     high_cnt [NUM_CH];
	integer seed;
	int     error_count;
	int     test_errors;
	int     tests_passed;
	int     tests_failed;

	spi_pwm_top spi_pwm_top_inst (
		.clk      (clk),
		.cs       (cs),
		.spi_sclk (spi_sclk),
		.spi_mosi (spi_mosi),
		.spi_ss   (spi_ss),
		.spi_miso (spi_miso),
		.pwm_out  (pwm_out)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns before the tests completed", WATCHDOG_NS);
		$display("Simulation finished: FAIL");
		$finish;
	end

	// Returns 1 ns after the n-th rising edge
	task automatic wait_clk(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic check_value(input string name, input int got, input int expected);
		if (got !== expected) begin
			$display("[ERROR] %0t ns %s: got %0d (0x%h), expected %0d (0x%h)",
				$time, name, got, got, expected, expected);
			error_count++;
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			tests_passed++;
			$display("[%0t ns] Test %s: ok", $time, name);
		end else begin
			tests_failed++;
			$display("[%0t ns] Test %s: %0d errors", $time, name, test_errors);
		end
		test_errors = 0;
	endtask

	// Drives one 16-bit frame with MOSI set on rising SCLK and MISO taken before falling SCLK
	task automatic spi_frame(input data_t cmd, input data_t wbyte, output data_t rbyte);
		logic [15:0] tx;
		tx = {cmd, wbyte};
		rbyte = '0;
		spi_ss = 1'b0;
		wait_clk(HALF_SCLK);
		for (int i = 15; i >= 0; i--) begin
			spi_sclk = 1'b1;
			spi_mosi = tx[i];
			wait_clk(HALF_SCLK);
			if (i < 8)
				rbyte = {rbyte[6:0], spi_miso};
			spi_sclk = 1'b0;
			wait_clk(HALF_SCLK);
		end
		spi_ss = 1'b1;
		spi_mosi = 1'b0;
		wait_clk(HALF_SCLK);
	endtask

	function automatic void model_write(input addr_t addr, input data_t data);
		if (addr != REG_ID)
			model_regs[addr] = data;	// ID register holds its constant
	endfunction

	function automatic data_t expected_read(input addr_t addr);
		if (addr == REG_ID)
			return 8'hA5;
		return model_regs[addr];
	endfunction

	task automatic spi_write(input addr_t addr, input data_t data);
		data_t rx_unused;
		spi_frame({5'b00000, addr}, data, rx_unused);
		model_write(addr, data);
	endtask

	task automatic spi_read(input addr_t addr, output data_t data);
		spi_frame({1'b1, 4'b0000, addr}, 8'h00, data);
	endtask

	task automatic read_check(input addr_t addr);
		data_t rx;
		spi_read(addr, rx);
		check_value($sformatf("spi_miso read of addr %0d", addr),
			int'(rx), int'(expected_read(addr)));
	endtask

	// Counts high cycles of each output over consecutive clk cycles
	task automatic measure_high(input int cycles);
		for (int n = 0; n < NUM_CH; n++)
			high_cnt[n] = 0;
		repeat (cycles) begin
			@(posedge clk);
			#1;
			for (int n = 0; n < NUM_CH; n++)
				if (pwm_out[n])
					high_cnt[n]++;
		end
	endtask

	initial begin : main_seq
		data_t p;
		data_t en_mask;
		int period;
		int k;
		int expected;

		cs           = 1'b1;
		spi_sclk     = 1'b0;
		spi_mosi     = 1'b0;
		spi_ss       = 1'b1;
		seed         = 93;
		error_count  = 0;
		test_errors  = 0;
		tests_passed = 0;
		tests_failed = 0;
		for (int a = 0; a < 8; a++)
			model_regs[a] = '0;

		wait_clk(RESET_CYCLES);
		cs = 1'b0;
		wait_clk(4);

		// Test 1
		check_value("pwm_out", int'(pwm_out), 0);
		for (int a = 0; a < 8; a++)
			read_check(addr_t'(a));
		finish_test("after_reset");

		// Test 2
		for (int a = 0; a < 7; a++)
			spi_write(addr_t'(a), 8'($random(seed)));
		for (int a = 0; a < 7; a++)
			read_check(addr_t'(a));
		finish_test("write_read_back");

		// Test 3
		spi_write(REG_ID, 8'($random(seed)));
		read_check(REG_ID);
		finish_test("id_read_only");

		// Test 4
		// Counters restart from zero with the new settings
		p = 8'($random(seed)) & 8'h03;
		period = 256 * (int'(p) + 1);
		spi_write(REG_ENABLE, 8'h00);
		for (int n = 0; n < NUM_CH; n++)
			spi_write(addr_t'(REG_DUTY0 + n), 8'($random(seed)) | 8'h01);	// Never zero
		spi_write(REG_PRESC, p);
		spi_write(REG_ENABLE, 8'h0F);
		wait_clk(period);	// New shadow duty loaded at the wrap
		measure_high(period);
		for (int n = 0; n < NUM_CH; n++)
			check_value($sformatf("pwm_out[%0d] high cycles", n), high_cnt[n],
				int'(model_regs[n]) * (int'(p) + 1));
		finish_test("duty_cycle");

		// Test 5
		k = $random(seed) & 3;
		en_mask = 8'h0F & ~(8'h01 << k);
		spi_write(REG_ENABLE, en_mask);
		measure_high(period);
		for (int n = 0; n < NUM_CH; n++) begin
			expected = (n == k) ? 0 : int'(model_regs[n]) * (int'(p) + 1);
			check_value($sformatf("pwm_out[%0d] high cycles", n), high_cnt[n], expected);
		end
		finish_test("disable");

		$display("Tests: %0d passed, %0d failed, %0d errors",
			tests_passed, tests_failed, error_count);
		if (error_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== spi_pwm_top.f ====
source/spi_pwm_pkg.sv
source/reg_bus_if.sv
source/spi_target.sv
source/pwm_reg_bank.sv
source/pwm_channel.sv
source/spi_pwm_top.sv
verif/spi_pwm_properties.sv
verif/spi_pwm_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module spi_pwm_tb -f spi_pwm_top.f

sim_out=$(./obj_dir/Vspi_pwm_tb || true)
echo "$sim_out"

if echo "$sim_out" | grep -q "Simulation finished: PASS"; then
	exit 0
else
	exit 1
fi
